// ==== hdl/exc_pkg.sv ====
// Shared exception manager definitions: FSM encodings, core modes, task-state and IDT layout
package exc_pkg;

	// Main sequencer state
	typedef enum logic [1:0] {
		MAIN_IDLE    = 2'd0,
		MAIN_JUMP    = 2'd1,
		MAIN_IRQ_SET = 2'd2,
		MAIN_IRQ_RET = 2'd3
	} main_state_t;

	// Sub state, shared by interrupt entry and return
	typedef enum logic [2:0] {
		SUB_VECTOR_REQ    = 3'd0,
		SUB_VECTOR_WAIT   = 3'd1,
		SUB_SPR_STORE     = 3'd2,
		SUB_SPR_LOAD_REQ  = 3'd3,
		SUB_SPR_LOAD_WAIT = 3'd4,
		SUB_FINISH        = 3'd5
	} sub_state_t;

	// Core mode codes, taken from status bits 6:5
	localparam logic [1:0] CORE_MODE_KERNEL = 2'd0;
	localparam logic [1:0] CORE_MODE_USER = 2'd3;
	localparam int PSR_MODE_LSB = 5;
	localparam int PSR_IRQ_ENABLE_BIT = 2;

	// Task state area, one 256 byte entry per task
	localparam logic [31:0] TST_KSPR_OFFSET = 32'h0000_0000;
	localparam logic [31:0] TST_USPR_OFFSET = 32'h0000_0004;
	localparam int TST_ENTRY_SHIFT = 8;
	localparam int TID_WIDTH = 14;

	// Interrupt descriptor table, 8 byte descriptors
	localparam int IRQ_NUM_WIDTH = 7;
	localparam int IDT_ENTRY_SHIFT = 3;
	localparam logic [31:0] IDT_HANDLER_OFFSET = 32'h0000_0004;

endpackage

// ==== hdl/exc_sysreg_snapshot.sv ====
// System register snapshot with task-state and descriptor address generation
`timescale 1ns/1ps

module exc_sysreg_snapshot #(
	parameter int DATA_WIDTH = 32
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic capture,
	input  logic [DATA_WIDTH-1:0] spr,
	input  logic [DATA_WIDTH-1:0] tidr,
	input  logic [DATA_WIDTH-1:0] tisr,
	input  logic [DATA_WIDTH-1:0] psr,
	input  logic [DATA_WIDTH-1:0] ppsr,
	input  logic [DATA_WIDTH-1:0] ppcr,
	input  logic [DATA_WIDTH-1:0] idtr,
	input  logic [exc_pkg::IRQ_NUM_WIDTH-1:0] irq_num,
	output logic [DATA_WIDTH-1:0] snap_spr,
	output logic [DATA_WIDTH-1:0] snap_ppcr,
	output logic [1:0] snap_psr_mode,
	output logic [1:0] snap_ppsr_mode,
	output logic [exc_pkg::TID_WIDTH-1:0] tid,
	output logic [DATA_WIDTH-1:0] kspr_addr,
	output logic [DATA_WIDTH-1:0] uspr_addr,
	output logic [DATA_WIDTH-1:0] vector_addr
);

	logic [DATA_WIDTH-1:0] tisr_q;
	logic [DATA_WIDTH-1:0] idtr_q;
	logic [exc_pkg::IRQ_NUM_WIDTH-1:0] irq_num_q;
	logic [DATA_WIDTH-1:0] tst_base;

	// Follow the core registers while the sequencer is idle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			snap_spr <= '0;
			snap_ppcr <= '0;
			snap_psr_mode <= exc_pkg::CORE_MODE_KERNEL;
			snap_ppsr_mode <= exc_pkg::CORE_MODE_KERNEL;
			tid <= '0;
			tisr_q <= '0;
			idtr_q <= '0;
			irq_num_q <= '0;
		end else if (capture) begin
			snap_spr <= spr;
			snap_ppcr <= ppcr;
			snap_psr_mode <= psr[exc_pkg::PSR_MODE_LSB +: 2];
			snap_ppsr_mode <= ppsr[exc_pkg::PSR_MODE_LSB +: 2];
			tid <= tidr[exc_pkg::TID_WIDTH-1:0];
			tisr_q <= tisr;
			idtr_q <= idtr;
			irq_num_q <= irq_num;
		end
	end

	// Entry of the current task in the task state area
	assign tst_base = tisr_q + (DATA_WIDTH'(tid) << exc_pkg::TST_ENTRY_SHIFT);
	assign kspr_addr = tst_base + DATA_WIDTH'(exc_pkg::TST_KSPR_OFFSET);
	assign uspr_addr = tst_base + DATA_WIDTH'(exc_pkg::TST_USPR_OFFSET);

	// Handler word of the descriptor for this irq
	assign vector_addr = idtr_q + (DATA_WIDTH'(irq_num_q) << exc_pkg::IDT_ENTRY_SHIFT)
		+ DATA_WIDTH'(exc_pkg::IDT_HANDLER_OFFSET);

endmodule

// ==== hdl/exc_word_reader.sv ====
// Single-word read agent on the load/store pipe
`timescale 1ns/1ps

module exc_word_reader #(
	parameter int DATA_WIDTH = 32
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic start,
	input  logic grant,
	input  logic rvalid,
	input  logic [DATA_WIDTH-1:0] rdata,
	output logic req,
	output logic done,
	output logic [DATA_WIDTH-1:0] data
);

	// High from start until the response is taken
	logic waiting;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			waiting <= 1'b0;
			req <= 1'b0;
			done <= 1'b0;
			data <= '0;
		end else begin
			done <= 1'b0;
			if (!waiting) begin
				if (start) begin
					waiting <= 1'b1;
					req <= 1'b1;
				end
			end else if (req) begin
				// Request stays up until the port takes it
				if (grant) begin
					req <= 1'b0;
				end
			end else if (rvalid) begin
				// Request already issued, so this response is ours
				waiting <= 1'b0;
				done <= 1'b1;
				data <= rdata;
			end
		end
	end

	// Sequencer never restarts a reader that is still working
	a_start_when_idle: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) start |-> !waiting
	) else $error("exc_word_reader: start while busy");

endmodule

// ==== hdl/exc_ldst_port.sv ====
// Fixed-priority merge of the read agents and the stack pointer store onto the load/store pipe
`timescale 1ns/1ps

module exc_ldst_port #(
	parameter int DATA_WIDTH = 32
) (
	input  logic vector_req,
	input  logic kspr_req,
	input  logic uspr_req,
	input  logic store_req,
	input  logic busy,
	input  logic [DATA_WIDTH-1:0] vector_addr,
	input  logic [DATA_WIDTH-1:0] kspr_addr,
	input  logic [DATA_WIDTH-1:0] uspr_addr,
	input  logic [DATA_WIDTH-1:0] store_addr,
	input  logic [DATA_WIDTH-1:0] store_data,
	input  logic [exc_pkg::TID_WIDTH-1:0] tid,
	input  logic active,
	output logic vector_grant,
	output logic kspr_grant,
	output logic uspr_grant,
	output logic store_grant,
	output logic ldst_use,
	output logic ldst_req,
	output logic ldst_rw,
	output logic [exc_pkg::TID_WIDTH-1:0] ldst_tid,
	output logic [DATA_WIDTH-1:0] ldst_addr,
	output logic [DATA_WIDTH-1:0] ldst_data
);

	// Priority uspr, kspr, vector, store; nothing goes out while busy
	assign uspr_grant = uspr_req && !busy;
	assign kspr_grant = kspr_req && !uspr_req && !busy;
	assign vector_grant = vector_req && !kspr_req && !uspr_req && !busy;
	assign store_grant = store_req && !vector_req && !kspr_req && !uspr_req && !busy;

	assign ldst_use = active;
	assign ldst_req = uspr_grant || kspr_grant || vector_grant || store_grant;
	assign ldst_rw = store_grant;
	assign ldst_tid = tid;
	assign ldst_data = store_data;

	always_comb begin
		if (uspr_req) begin
			ldst_addr = uspr_addr;
		end else if (kspr_req) begin
			ldst_addr = kspr_addr;
		end else if (vector_req) begin
			ldst_addr = vector_addr;
		end else begin
			ldst_addr = store_addr;
		end
	end

	// Sequencer runs one pipe access at a time
	always_comb begin
		assert ($onehot0({uspr_req, kspr_req, vector_req, store_req}))
		else $error("exc_ldst_port: more than one request source active");
	end

endmodule

// ==== hdl/exc_sequencer.sv ====
// Exception sequencer with jump, interrupt entry and return FSMs and core-side outputs
`timescale 1ns/1ps

module exc_sequencer #(
	parameter int DATA_WIDTH = 32
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic jump,
	input  logic irq_return,
	input  logic irq_req,
	input  logic interrupt_lock,
	input  logic irq_enable,
	input  logic [DATA_WIDTH-1:0] jump_addr,
	input  logic [DATA_WIDTH-1:0] pcr,
	input  logic [DATA_WIDTH-1:0] irq_fi0r,
	input  logic [DATA_WIDTH-1:0] snap_spr,
	input  logic [DATA_WIDTH-1:0] snap_ppcr,
	input  logic [1:0] snap_psr_mode,
	input  logic [1:0] snap_ppsr_mode,
	input  logic vector_done,
	input  logic kspr_done,
	input  logic uspr_done,
	input  logic store_grant,
	input  logic ldst_busy,
	input  logic ldst_rvalid,
	input  logic [DATA_WIDTH-1:0] vector_data,
	input  logic [DATA_WIDTH-1:0] kspr_data,
	input  logic [DATA_WIDTH-1:0] uspr_data,
	output logic capture,
	output logic active,
	output logic vector_start,
	output logic kspr_start,
	output logic uspr_start,
	output logic store_req,
	output logic store_to_kspr,
	output logic [DATA_WIDTH-1:0] store_data,
	output logic register_lock,
	output logic pipeline_stop,
	output logic refresh,
	output logic restart,
	output logic pc_set,
	output logic [DATA_WIDTH-1:0] pc,
	output logic ppcr_set,
	output logic [DATA_WIDTH-1:0] ppcr_out,
	output logic fi0r_set,
	output logic [DATA_WIDTH-1:0] fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic spr_write,
	output logic [DATA_WIDTH-1:0] spr_out,
	output logic irq_ack
);

	exc_pkg::main_state_t main_state;
	exc_pkg::sub_state_t sub_state;
	logic irq_pending;
	logic branch_active;
	logic [DATA_WIDTH-1:0] branch_addr;
	logic irq_cond;
	logic entry;

	assign irq_cond = irq_req && !interrupt_lock && irq_enable;
	assign entry = (main_state == exc_pkg::MAIN_IRQ_SET);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			main_state <= exc_pkg::MAIN_IDLE;
			sub_state <= exc_pkg::SUB_VECTOR_REQ;
			irq_pending <= 1'b0;
			branch_active <= 1'b0;
			branch_addr <= '0;
			refresh <= 1'b0;
			ppcr_set <= 1'b0;
			ppcr_out <= '0;
			fi0r <= '0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			spr_write <= 1'b0;
			spr_out <= '0;
			irq_ack <= 1'b0;
			vector_start <= 1'b0;
			kspr_start <= 1'b0;
			uspr_start <= 1'b0;
			store_req <= 1'b0;
			store_data <= '0;
		end else begin
			// Pulses last one cycle unless set below
			branch_active <= 1'b0;
			refresh <= 1'b0;
			ppcr_set <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			spr_write <= 1'b0;
			irq_ack <= 1'b0;
			vector_start <= 1'b0;
			kspr_start <= 1'b0;
			uspr_start <= 1'b0;
			case (main_state)
				exc_pkg::MAIN_IDLE: begin
					if (jump) begin
						main_state <= exc_pkg::MAIN_JUMP;
						irq_pending <= irq_req && irq_enable;
						branch_addr <= jump_addr;
						refresh <= 1'b1;
					end else if (irq_cond) begin
						main_state <= exc_pkg::MAIN_IRQ_SET;
						refresh <= 1'b1;
						ppcr_set <= 1'b1;
						ppcr_out <= pcr;
						set_irq_mode <= 1'b1;
						fi0r <= irq_fi0r;
					end else if (irq_return) begin
						main_state <= exc_pkg::MAIN_IRQ_RET;
						refresh <= 1'b1;
					end
				end
				exc_pkg::MAIN_JUMP: begin
					irq_pending <= 1'b0;
					if (irq_pending) begin
						// Jump target becomes the return address of the entry
						main_state <= exc_pkg::MAIN_IRQ_SET;
						refresh <= 1'b1;
						ppcr_set <= 1'b1;
						ppcr_out <= branch_addr;
						set_irq_mode <= 1'b1;
						fi0r <= irq_fi0r;
					end else begin
						main_state <= exc_pkg::MAIN_IDLE;
						branch_active <= 1'b1;
					end
				end
				default: begin
					case (sub_state)
						exc_pkg::SUB_VECTOR_REQ: begin
							if (entry) begin
								vector_start <= 1'b1;
								sub_state <= exc_pkg::SUB_VECTOR_WAIT;
							end else begin
								// Return swaps stacks only when going back to user mode
								branch_addr <= snap_ppcr;
								sub_state <= (snap_ppsr_mode == exc_pkg::CORE_MODE_USER) ?
									exc_pkg::SUB_SPR_STORE : exc_pkg::SUB_FINISH;
							end
						end
						exc_pkg::SUB_VECTOR_WAIT: begin
							if (vector_done) begin
								branch_addr <= vector_data;
								sub_state <= (snap_psr_mode == exc_pkg::CORE_MODE_KERNEL) ?
									exc_pkg::SUB_FINISH : exc_pkg::SUB_SPR_STORE;
							end
						end
						exc_pkg::SUB_SPR_STORE: begin
							if (!ldst_busy) begin
								store_req <= 1'b1;
								store_data <= snap_spr;
								sub_state <= exc_pkg::SUB_SPR_LOAD_REQ;
							end
						end
						exc_pkg::SUB_SPR_LOAD_REQ: begin
							if (store_req) begin
								if (store_grant) begin
									store_req <= 1'b0;
								end
							end else if (ldst_rvalid) begin
								// Fetch the other stack pointer once the store is acknowledged
								kspr_start <= entry;
								uspr_start <= !entry;
								sub_state <= exc_pkg::SUB_SPR_LOAD_WAIT;
							end
						end
						exc_pkg::SUB_SPR_LOAD_WAIT: begin
							if (kspr_done || uspr_done) begin
								spr_write <= 1'b1;
								spr_out <= entry ? kspr_data : uspr_data;
								sub_state <= exc_pkg::SUB_FINISH;
							end
						end
						default: begin
							main_state <= exc_pkg::MAIN_IDLE;
							sub_state <= exc_pkg::SUB_VECTOR_REQ;
							branch_active <= 1'b1;
							irq_ack <= entry;
							clr_irq_mode <= !entry;
						end
					endcase
				end
			endcase
		end
	end

	assign capture = (main_state == exc_pkg::MAIN_IDLE);
	assign active = !capture;
	// Entry saves the user stack pointer and return the kernel one
	assign store_to_kspr = (main_state == exc_pkg::MAIN_IRQ_RET);

	assign register_lock = active || (!jump && irq_cond) || refresh || branch_active;
	assign pipeline_stop = active || (!jump && irq_cond);
	assign restart = branch_active;
	assign pc_set = branch_active;
	assign pc = branch_addr;
	assign fi0r_set = entry && (sub_state == exc_pkg::SUB_FINISH);

	// Sub FSM always restarts from its first state
	a_idle_sub_state: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(main_state == exc_pkg::MAIN_IDLE) |-> (sub_state == exc_pkg::SUB_VECTOR_REQ)
	) else $error("exc_sequencer: idle with sub state %0d", sub_state);

endmodule

// ==== hdl/exception_manager.sv ====
// Exception manager top level: snapshot, read agents, pipe port and sequencer
`timescale 1ns/1ps

module exception_manager #(
	parameter int DATA_WIDTH = 32
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic jump,
	input  logic [DATA_WIDTH-1:0] jump_addr,
	input  logic irq_return,
	input  logic irq_req,
	input  logic [exc_pkg::IRQ_NUM_WIDTH-1:0] irq_num,
	input  logic [DATA_WIDTH-1:0] irq_fi0r,
	input  logic interrupt_lock,
	input  logic [DATA_WIDTH-1:0] spr,
	input  logic [DATA_WIDTH-1:0] tidr,
	input  logic [DATA_WIDTH-1:0] tisr,
	input  logic [DATA_WIDTH-1:0] psr,
	input  logic [DATA_WIDTH-1:0] ppsr,
	input  logic [DATA_WIDTH-1:0] pcr,
	input  logic [DATA_WIDTH-1:0] ppcr,
	input  logic [DATA_WIDTH-1:0] idtr,
	output logic register_lock,
	output logic pipeline_stop,
	output logic refresh,
	output logic restart,
	output logic pc_set,
	output logic [DATA_WIDTH-1:0] pc,
	output logic ppcr_set,
	output logic [DATA_WIDTH-1:0] ppcr_out,
	output logic fi0r_set,
	output logic [DATA_WIDTH-1:0] fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic spr_write,
	output logic [DATA_WIDTH-1:0] spr_out,
	output logic irq_ack,
	output logic ldst_use,
	output logic ldst_req,
	output logic ldst_rw,
	output logic [exc_pkg::TID_WIDTH-1:0] ldst_tid,
	output logic [DATA_WIDTH-1:0] ldst_addr,
	output logic [DATA_WIDTH-1:0] ldst_data,
	input  logic ldst_busy,
	input  logic ldst_rvalid,
	input  logic [DATA_WIDTH-1:0] ldst_rdata
);

	logic capture;
	logic active;
	logic [DATA_WIDTH-1:0] snap_spr;
	logic [DATA_WIDTH-1:0] snap_ppcr;
	logic [1:0] snap_psr_mode;
	logic [1:0] snap_ppsr_mode;
	logic [exc_pkg::TID_WIDTH-1:0] tid;
	logic [DATA_WIDTH-1:0] kspr_addr;
	logic [DATA_WIDTH-1:0] uspr_addr;
	logic [DATA_WIDTH-1:0] vector_addr;
	logic [DATA_WIDTH-1:0] store_addr;
	logic [DATA_WIDTH-1:0] store_data;
	logic store_to_kspr;
	logic store_req;
	logic store_grant;
	logic vector_start;
	logic vector_req;
	logic vector_grant;
	logic vector_done;
	logic [DATA_WIDTH-1:0] vector_data;
	logic kspr_start;
	logic kspr_req;
	logic kspr_grant;
	logic kspr_done;
	logic [DATA_WIDTH-1:0] kspr_data;
	logic uspr_start;
	logic uspr_req;
	logic uspr_grant;
	logic uspr_done;
	logic [DATA_WIDTH-1:0] uspr_data;

	// Stack pointer slot written before the swap
	assign store_addr = store_to_kspr ? kspr_addr : uspr_addr;

	exc_sysreg_snapshot #(.DATA_WIDTH(DATA_WIDTH)) u_snapshot (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .capture(capture),
		.spr(spr), .tidr(tidr), .tisr(tisr), .psr(psr), .ppsr(ppsr),
		.ppcr(ppcr), .idtr(idtr), .irq_num(irq_num),
		.snap_spr(snap_spr), .snap_ppcr(snap_ppcr),
		.snap_psr_mode(snap_psr_mode), .snap_ppsr_mode(snap_ppsr_mode), .tid(tid),
		.kspr_addr(kspr_addr), .uspr_addr(uspr_addr), .vector_addr(vector_addr)
	);

	exc_word_reader #(.DATA_WIDTH(DATA_WIDTH)) u_vector (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .start(vector_start), .grant(vector_grant),
		.rvalid(ldst_rvalid), .rdata(ldst_rdata),
		.req(vector_req), .done(vector_done), .data(vector_data)
	);

	exc_word_reader #(.DATA_WIDTH(DATA_WIDTH)) u_kspr (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .start(kspr_start), .grant(kspr_grant),
		.rvalid(ldst_rvalid), .rdata(ldst_rdata),
		.req(kspr_req), .done(kspr_done), .data(kspr_data)
	);

	exc_word_reader #(.DATA_WIDTH(DATA_WIDTH)) u_uspr (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .start(uspr_start), .grant(uspr_grant),
		.rvalid(ldst_rvalid), .rdata(ldst_rdata),
		.req(uspr_req), .done(uspr_done), .data(uspr_data)
	);

	exc_ldst_port #(.DATA_WIDTH(DATA_WIDTH)) u_ldst_port (
		.vector_req(vector_req), .kspr_req(kspr_req), .uspr_req(uspr_req),
		.store_req(store_req), .busy(ldst_busy),
		.vector_addr(vector_addr), .kspr_addr(kspr_addr), .uspr_addr(uspr_addr),
		.store_addr(store_addr), .store_data(store_data), .tid(tid), .active(active),
		.vector_grant(vector_grant), .kspr_grant(kspr_grant), .uspr_grant(uspr_grant),
		.store_grant(store_grant), .ldst_use(ldst_use), .ldst_req(ldst_req),
		.ldst_rw(ldst_rw), .ldst_tid(ldst_tid), .ldst_addr(ldst_addr), .ldst_data(ldst_data)
	);

	exc_sequencer #(.DATA_WIDTH(DATA_WIDTH)) u_sequencer (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .jump(jump), .irq_return(irq_return),
		.irq_req(irq_req), .interrupt_lock(interrupt_lock),
		.irq_enable(psr[exc_pkg::PSR_IRQ_ENABLE_BIT]),
		.jump_addr(jump_addr), .pcr(pcr), .irq_fi0r(irq_fi0r),
		.snap_spr(snap_spr), .snap_ppcr(snap_ppcr),
		.snap_psr_mode(snap_psr_mode), .snap_ppsr_mode(snap_ppsr_mode),
		.vector_done(vector_done), .kspr_done(kspr_done), .uspr_done(uspr_done),
		.store_grant(store_grant), .ldst_busy(ldst_busy), .ldst_rvalid(ldst_rvalid),
		.vector_data(vector_data), .kspr_data(kspr_data), .uspr_data(uspr_data),
		.capture(capture), .active(active), .vector_start(vector_start),
		.kspr_start(kspr_start), .uspr_start(uspr_start), .store_req(store_req),
		.store_to_kspr(store_to_kspr), .store_data(store_data),
		.register_lock(register_lock), .pipeline_stop(pipeline_stop),
		.refresh(refresh), .restart(restart), .pc_set(pc_set), .pc(pc),
		.ppcr_set(ppcr_set), .ppcr_out(ppcr_out), .fi0r_set(fi0r_set), .fi0r(fi0r),
		.set_irq_mode(set_irq_mode), .clr_irq_mode(clr_irq_mode),
		.spr_write(spr_write), .spr_out(spr_out), .irq_ack(irq_ack)
	);

endmodule

// ==== tb/tb_ldst_memory.sv ====
// Load/store memory model with random busy and a 1 to 4 cycle response delay
`timescale 1ns/1ps

module tb_ldst_memory #(
	parameter int DATA_WIDTH = 32
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic req,
	input  logic rw,
	input  logic [DATA_WIDTH-1:0] addr,
	input  logic rand_busy,
	input  logic [1:0] rand_delay,
	output logic busy,
	output logic rvalid,
	output logic [DATA_WIDTH-1:0] rdata,
	output int wr_count,
	output int resp_count
);

	localparam logic [DATA_WIDTH-1:0] READ_MASK = DATA_WIDTH'(32'h5a5a_0000);

	int req_seen;
	logic [DATA_WIDTH-1:0] req_addr;
	logic req_rw;
	logic counting;
	logic [1:0] left;
	logic fire;

	// Take the request at the rising edge
	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_seen <= 0;
			wr_count <= 0;
			req_addr <= '0;
			req_rw <= 1'b0;
		end else if (req) begin
			req_seen <= req_seen + 1;
			req_addr <= addr;
			req_rw <= rw;
			if (rw) begin
				wr_count <= wr_count + 1;
			end
		end
	end

	// Outputs change on the falling edge only
	always @(negedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			resp_count <= 0;
			counting <= 1'b0;
			left <= 2'd0;
		end else begin
			fire = 1'b0;
			busy <= rand_busy;
			rvalid <= 1'b0;
			if (counting) begin
				if (left == 2'd0) begin
					fire = 1'b1;
				end else begin
					left <= left - 2'd1;
				end
			end else if (req_seen != resp_count) begin
				if (rand_delay == 2'd0) begin
					fire = 1'b1;
				end else begin
					counting <= 1'b1;
					left <= rand_delay - 2'd1;
				end
			end
			if (fire) begin
				// Write acknowledge carries no data
				counting <= 1'b0;
				rvalid <= 1'b1;
				rdata <= req_rw ? '0 : (req_addr ^ READ_MASK);
				resp_count <= resp_count + 1;
			end
		end
	end

endmodule

// ==== tb/tb_exception_manager.sv ====
// Exception manager testbench with clock, reset, stimulus, protocol monitor and result checks
`timescale 1ns/1ps

module tb_exception_manager;

	localparam int DATA_WIDTH = 32;
	localparam logic [31:0] READ_MASK = 32'h5a5a_0000;
	// Ten scenarios of at most about 60 cycles each with a slow and busy memory
	localparam int TIMEOUT_CYCLES = 3000;

	logic iCLOCK;
	logic inRESET;
	logic jump;
	logic [31:0] jump_addr;
	logic irq_return;
	logic irq_req;
	logic [6:0] irq_num;
	logic [31:0] irq_fi0r;
	logic interrupt_lock;
	logic [31:0] spr;
	logic [31:0] tidr;
	logic [31:0] tisr;
	logic [31:0] psr;
	logic [31:0] ppsr;
	logic [31:0] pcr;
	logic [31:0] ppcr;
	logic [31:0] idtr;
	logic register_lock;
	logic pipeline_stop;
	logic refresh;
	logic restart;
	logic pc_set;
	logic [31:0] pc;
	logic ppcr_set;
	logic [31:0] ppcr_out;
	logic fi0r_set;
	logic [31:0] fi0r;
	logic set_irq_mode;
	logic clr_irq_mode;
	logic spr_write;
	logic [31:0] spr_out;
	logic irq_ack;
	logic ldst_use;
	logic ldst_req;
	logic ldst_rw;
	logic [13:0] ldst_tid;
	logic [31:0] ldst_addr;
	logic [31:0] ldst_data;
	logic ldst_busy;
	logic ldst_rvalid;
	logic [31:0] ldst_rdata;

	logic [31:0] lfsr = 32'h0000_7fc3;
	logic rand_busy = 1'b0;
	logic [1:0] rand_delay = 2'd0;
	int wr_count;
	int resp_count;
	int cycle_count = 0;
	int outstanding = 0;
	int req_total = 0;
	int entry_count = 0;
	int spr_count = 0;
	int pc_set_count = 0;
	logic fi0r_set_d = 1'b0;
	logic [31:0] last_ppcr = '0;
	logic [31:0] log_addr[$];
	logic log_rw[$];
	logic [31:0] log_data[$];

	exception_manager #(.DATA_WIDTH(DATA_WIDTH)) i_exception_manager (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .jump(jump), .jump_addr(jump_addr),
		.irq_return(irq_return), .irq_req(irq_req), .irq_num(irq_num),
		.irq_fi0r(irq_fi0r), .interrupt_lock(interrupt_lock),
		.spr(spr), .tidr(tidr), .tisr(tisr), .psr(psr), .ppsr(ppsr),
		.pcr(pcr), .ppcr(ppcr), .idtr(idtr),
		.register_lock(register_lock), .pipeline_stop(pipeline_stop),
		.refresh(refresh), .restart(restart), .pc_set(pc_set), .pc(pc),
		.ppcr_set(ppcr_set), .ppcr_out(ppcr_out), .fi0r_set(fi0r_set), .fi0r(fi0r),
		.set_irq_mode(set_irq_mode), .clr_irq_mode(clr_irq_mode),
		.spr_write(spr_write), .spr_out(spr_out), .irq_ack(irq_ack),
		.ldst_use(ldst_use), .ldst_req(ldst_req), .ldst_rw(ldst_rw),
		.ldst_tid(ldst_tid), .ldst_addr(ldst_addr), .ldst_data(ldst_data),
		.ldst_busy(ldst_busy), .ldst_rvalid(ldst_rvalid), .ldst_rdata(ldst_rdata)
	);

	tb_ldst_memory #(.DATA_WIDTH(DATA_WIDTH)) u_memory (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .req(ldst_req), .rw(ldst_rw),
		.addr(ldst_addr), .rand_busy(rand_busy), .rand_delay(rand_delay),
		.busy(ldst_busy), .rvalid(ldst_rvalid), .rdata(ldst_rdata),
		.wr_count(wr_count), .resp_count(resp_count)
	);

	always #5 iCLOCK = ~iCLOCK;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic next_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	// Handler word of a descriptor
	function automatic logic [31:0] vector_slot(input logic [31:0] base, input logic [6:0] num);
		return base + {22'd0, num, 3'd0} + 32'd4;
	endfunction

	// Stack pointer slot of the task entry
	function automatic logic [31:0] task_slot(input logic [31:0] base, input logic [31:0] id,
		input logic [31:0] offset);
		return base + {10'd0, id[13:0], 8'd0} + offset;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else stop_on_error($sformatf("ERR %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_access(input int idx, input logic rw, input logic [31:0] addr,
		input logic [31:0] data);
		check_value("ldst_rw", 32'(log_rw[idx]), 32'(rw));
		check_value("ldst_addr", log_addr[idx], addr);
		if (rw) begin
			check_value("ldst_data", log_data[idx], data);
		end
	endtask

	// Core held while an operation runs
	task automatic check_stalled();
		check_value("register_lock", 32'(register_lock), 32'd1);
		check_value("pipeline_stop", 32'(pipeline_stop), 32'd1);
	endtask

	// Nothing held or pulsed once the block is idle again
	task automatic check_quiet();
		check_value("register_lock", 32'(register_lock), 32'd0);
		check_value("pipeline_stop", 32'(pipeline_stop), 32'd0);
		check_value("refresh", 32'(refresh), 32'd0);
		check_value("restart", 32'(restart), 32'd0);
	endtask

	task automatic clear_log();
		log_addr.delete();
		log_rw.delete();
		log_data.delete();
	endtask

	always @(negedge iCLOCK) begin
		rand_busy <= next_bit() & next_bit();
		rand_delay <= {next_bit(), next_bit()};
	end

	always @(posedge iCLOCK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_on_error($sformatf("Timeout, the run did not end within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	// Pipe protocol and pulse relations sampled at the rising edge
	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			if (cycle_count > 1) begin
				assert (!(pc_set || irq_ack || ppcr_set || fi0r_set || set_irq_mode ||
					clr_irq_mode || spr_write || refresh || ldst_req))
				else stop_on_error("A pulse or request output is high during reset");
			end
		end else begin
			assert (!(ldst_req && ldst_busy))
			else stop_on_error("ldst_req is high while ldst_busy is high");
			if (ldst_rvalid) begin
				assert (outstanding == 1)
				else stop_on_error("A response arrived with no request outstanding");
				outstanding = 0;
			end
			if (ldst_req) begin
				assert (outstanding == 0)
				else stop_on_error("A new request was issued before the previous response");
				assert (ldst_use)
				else stop_on_error("ldst_req is high while ldst_use is low");
				check_value("ldst_tid", {18'd0, ldst_tid}, {18'd0, tidr[13:0]});
				outstanding = 1;
				req_total++;
				log_addr.push_back(ldst_addr);
				log_rw.push_back(ldst_rw);
				log_data.push_back(ldst_data);
			end
			assert (set_irq_mode == ppcr_set)
			else stop_on_error("set_irq_mode and ppcr_set are not pulsed together");
			assert (restart == pc_set)
			else stop_on_error("restart and pc_set are not pulsed together");
			if (irq_ack) begin
				assert (pc_set && fi0r_set_d)
				else stop_on_error("irq_ack without pc_set or without fi0r_set one cycle before");
			end
			if (clr_irq_mode) begin
				assert (pc_set)
				else stop_on_error("clr_irq_mode without pc_set in the same cycle");
			end
			if (set_irq_mode) begin
				entry_count++;
				last_ppcr = ppcr_out;
			end
			if (spr_write) begin
				spr_count++;
			end
			if (pc_set) begin
				pc_set_count++;
			end
		end
		fi0r_set_d = fi0r_set;
	end

	task automatic run_jump(input logic [31:0] target);
		int waited;
		int pcs_before;
		pcs_before = pc_set_count;
		jump <= 1'b1;
		jump_addr <= target;
		@(negedge iCLOCK);
		waited = 1;
		jump <= 1'b0;
		check_value("refresh", 32'(refresh), 32'd1);
		check_stalled();
		while (!pc_set) begin
			@(negedge iCLOCK);
			waited++;
		end
		check_value("jump to pc_set cycles", 32'(waited), 32'd2);
		check_value("pc", pc, target);
		@(negedge iCLOCK);
		check_value("pc_set", 32'(pc_set), 32'd0);
		check_value("pc_set pulses", 32'(pc_set_count - pcs_before), 32'd1);
		check_quiet();
	endtask

	// Entry from idle or from a jump that finds the interrupt pending
	task automatic run_entry(input logic with_jump, input logic [31:0] target,
		input logic user_mode);
		logic [31:0] vec;
		logic [31:0] kslot;
		logic [31:0] uslot;
		logic [31:0] exp_ppcr;
		int entries_before;
		int sprs_before;
		int pcs_before;
		int wr_before;
		vec = vector_slot(idtr, irq_num);
		kslot = task_slot(tisr, tidr, 32'h0);
		uslot = task_slot(tisr, tidr, 32'h4);
		exp_ppcr = with_jump ? target : pcr;
		entries_before = entry_count;
		sprs_before = spr_count;
		pcs_before = pc_set_count;
		wr_before = wr_count;
		clear_log();
		irq_req <= 1'b1;
		if (with_jump) begin
			jump <= 1'b1;
			jump_addr <= target;
		end
		@(negedge iCLOCK);
		jump <= 1'b0;
		if (!with_jump) begin
			check_value("set_irq_mode", 32'(set_irq_mode), 32'd1);
		end
		check_value("refresh", 32'(refresh), 32'd1);
		while (!irq_ack) begin
			check_stalled();
			@(negedge iCLOCK);
		end
		irq_req <= 1'b0;
		check_value("pc", pc, vec ^ READ_MASK);
		check_value("fi0r", fi0r, irq_fi0r);
		check_value("ppcr_out", last_ppcr, exp_ppcr);
		check_access(0, 1'b0, vec, 32'h0);
		if (user_mode) begin
			check_value("ldst requests", 32'(log_addr.size()), 32'd3);
			check_access(1, 1'b1, uslot, spr);
			check_access(2, 1'b0, kslot, 32'h0);
			check_value("spr_out", spr_out, kslot ^ READ_MASK);
		end else begin
			check_value("ldst requests", 32'(log_addr.size()), 32'd1);
		end
		@(negedge iCLOCK);
		check_value("set_irq_mode pulses", 32'(entry_count - entries_before), 32'd1);
		check_value("pc_set pulses", 32'(pc_set_count - pcs_before), 32'd1);
		check_value("spr_write pulses", 32'(spr_count - sprs_before), 32'(user_mode));
		check_value("memory writes", 32'(wr_count - wr_before), 32'(user_mode));
		check_quiet();
	endtask

	task automatic run_return(input logic user_mode);
		logic [31:0] kslot;
		logic [31:0] uslot;
		int sprs_before;
		kslot = task_slot(tisr, tidr, 32'h0);
		uslot = task_slot(tisr, tidr, 32'h4);
		sprs_before = spr_count;
		clear_log();
		irq_return <= 1'b1;
		@(negedge iCLOCK);
		irq_return <= 1'b0;
		check_value("refresh", 32'(refresh), 32'd1);
		while (!clr_irq_mode) begin
			check_stalled();
			@(negedge iCLOCK);
		end
		check_value("pc_set", 32'(pc_set), 32'd1);
		check_value("pc", pc, ppcr);
		if (user_mode) begin
			check_value("ldst requests", 32'(log_addr.size()), 32'd2);
			check_access(0, 1'b1, kslot, spr);
			check_access(1, 1'b0, uslot, 32'h0);
			check_value("spr_out", spr_out, uslot ^ READ_MASK);
		end else begin
			check_value("ldst requests", 32'(log_addr.size()), 32'd0);
		end
		@(negedge iCLOCK);
		check_value("spr_write pulses", 32'(spr_count - sprs_before), 32'(user_mode));
		check_quiet();
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		jump = 1'b0;
		jump_addr = '0;
		irq_return = 1'b0;
		irq_req = 1'b0;
		irq_num = 7'd19;
		irq_fi0r = 32'hcafe_0001;
		interrupt_lock = 1'b0;
		spr = 32'h0000_7ff0;
		tidr = 32'h0000_4025;
		tisr = 32'h0010_0000;
		// Kernel mode with interrupts enabled
		psr = 32'h0000_0004;
		ppsr = 32'h0000_0000;
		pcr = 32'h0000_4000;
		ppcr = 32'h0000_5000;
		idtr = 32'h0002_0000;
		repeat (16) @(negedge iCLOCK);
		inRESET <= 1'b1;
		repeat (4) @(negedge iCLOCK);

		run_jump(32'h0000_1240);
		run_entry(1'b0, 32'h0, 1'b0);
		@(negedge iCLOCK);
		psr <= 32'h0000_0064;
		@(negedge iCLOCK);
		run_entry(1'b0, 32'h0, 1'b1);
		@(negedge iCLOCK);
		ppsr <= 32'h0000_0060;
		@(negedge iCLOCK);
		run_return(1'b1);
		@(negedge iCLOCK);
		ppsr <= 32'h0000_0000;
		psr <= 32'h0000_0004;
		@(negedge iCLOCK);
		run_return(1'b0);
		@(negedge iCLOCK);
		run_entry(1'b1, 32'h0000_3a3c, 1'b0);

		// More user-mode round trips with other tasks and vectors
		@(negedge iCLOCK);
		irq_num <= 7'd100;
		tidr <= 32'h0000_1234;
		psr <= 32'h0000_0064;
		ppsr <= 32'h0000_0060;
		irq_fi0r <= 32'h0bad_f00d;
		@(negedge iCLOCK);
		run_entry(1'b0, 32'h0, 1'b1);
		run_return(1'b1);
		@(negedge iCLOCK);
		irq_num <= 7'd3;
		tidr <= 32'h0000_3fff;
		spr <= 32'h00ab_cd00;
		@(negedge iCLOCK);
		run_entry(1'b0, 32'h0, 1'b1);
		run_return(1'b1);

		repeat (8) @(negedge iCLOCK);
		check_value("outstanding requests", 32'(outstanding), 32'd0);
		check_value("ldst_rvalid count", 32'(resp_count), 32'(req_total));
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/exc_pkg.sv
hdl/exc_sysreg_snapshot.sv
hdl/exc_word_reader.sv
hdl/exc_ldst_port.sv
hdl/exc_sequencer.sv
hdl/exception_manager.sv
tb/tb_ldst_memory.sv
tb/tb_exception_manager.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_exception_manager
FILELIST  := list.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
BUILD     := obj_dir
LOG       := sim.log
PASS      := NO ERRORS

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(wildcard hdl/*.sv) $(wildcard tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
